/* list.f */
udp_echo_pkg.sv
udp_port_filter.sv
udp_payload_fifo.sv
udp_reply_tx.sv
udp_echo_top.sv
udp_echo_checker.sv
tb_udp_echo.sv

/* run.sh */
#!/bin/sh
# Build and run the UDP echo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_udp_echo -f list.f -o sim_udp_echo

status=0
out=$(./obj_dir/sim_udp_echo) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1

/* tb_udp_echo.sv */
/*
 * UDP echo responder testbench
 * Random matching and non-matching frames into the DUT with random
 * back-pressure on the transmit side, checked by udp_echo_checker
 */
module tb_udp_echo;
    timeunit 1ns;
    timeprecision 1ps;
    import udp_echo_pkg::*;

    logic              clk;
    logic              rst;
    logic              rx_hdr_valid;
    logic              rx_hdr_ready;
    logic [IP_W-1:0]   rx_ip_source_ip;
    logic [PORT_W-1:0] rx_source_port;
    logic [PORT_W-1:0] rx_dest_port;
    logic [PORT_W-1:0] rx_length;
    logic [DATA_W-1:0] rx_payload_tdata;
    logic [KEEP_W-1:0] rx_payload_tkeep;
    logic              rx_payload_tvalid;
    logic              rx_payload_tready;
    logic              rx_payload_tlast;
    logic              rx_payload_tuser;
    logic              tx_hdr_valid;
    logic              tx_hdr_ready;
    logic [IP_W-1:0]   tx_ip_dest_ip;
    logic [PORT_W-1:0] tx_source_port;
    logic [PORT_W-1:0] tx_dest_port;
    logic [PORT_W-1:0] tx_length;
    logic [DATA_W-1:0] tx_payload_tdata;
    logic [KEEP_W-1:0] tx_payload_tkeep;
    logic              tx_payload_tvalid;
    logic              tx_payload_tready;
    logic              tx_payload_tlast;
    logic              tx_payload_tuser;
    logic [7:0]        led;

    int     error_count;
    int     pending;
    int     matched_count;
    int     echoed_count;
    integer seed = 85;
    int     num_frames = 60;
    int     wait_limit = 2000;
    int     sent_count;
    logic   timed_out;

    udp_echo_top DUT (.*);

    udp_echo_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Transmit side stalls about a quarter of the time
    always @(posedge clk) begin
        if (!rst) begin
            tx_hdr_ready      <= (next_random() % 4) != 0;
            tx_payload_tready <= (next_random() % 4) != 0;
        end
    end

    task automatic wait_hdr_accepted();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!rx_hdr_ready && !timed_out) begin
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: receive header not accepted after %0d cycles", wait_limit);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic wait_beat_accepted();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!rx_payload_tready && !timed_out) begin
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: receive payload word not accepted after %0d cycles",
                         wait_limit);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    // One frame of 1 to 8 words, sent to the echo port about half the time
    task automatic send_frame();
        int          nwords;
        logic [31:0] r;
        r      = next_random();
        nwords = 1 + int'(r[2:0]);
        r      = next_random();
        rx_hdr_valid    <= 1'b1;
        rx_dest_port    <= r[0] ? ECHO_PORT : r[31:16];
        rx_ip_source_ip <= next_random();
        r      = next_random();
        rx_source_port  <= r[15:0];
        rx_length       <= 16'(8 + 8 * nwords);
        wait_hdr_accepted();
        rx_hdr_valid <= 1'b0;
        for (int k = 0; k < nwords && !timed_out; k++) begin
            r = next_random();
            if (r[1:0] == 2'b00) begin
                rx_payload_tvalid <= 1'b0;
                @(posedge clk);
            end
            rx_payload_tvalid <= 1'b1;
            rx_payload_tdata  <= {next_random(), next_random()};
            rx_payload_tkeep  <= (k == nwords - 1) ? (8'hFF >> r[4:2]) : 8'hFF;
            rx_payload_tlast  <= (k == nwords - 1);
            rx_payload_tuser  <= (k == nwords - 1) && (r[7:5] == 3'b000);
            wait_beat_accepted();
        end
        rx_payload_tvalid <= 1'b0;
        sent_count++;
    endtask

    initial begin
        int waited;
        rst               = 1'b1;
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tkeep  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        tx_hdr_ready      = 1'b0;
        tx_payload_tready = 1'b0;
        sent_count        = 0;
        timed_out         = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < num_frames && !timed_out; i++) begin
            send_frame();
        end
        // Model takes in the last accepted word on this edge
        @(posedge clk);
        // Drain everything the model still expects
        waited = 0;
        while (pending != 0 && !timed_out) begin
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: %0d expected items never left the DUT", pending);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
        // Quiet period to catch stray outputs
        repeat (20) @(posedge clk);
        $display("frames sent %0d, matched %0d, echoed %0d, errors %0d",
                 sent_count, matched_count, echoed_count, error_count);
        if (timed_out || error_count != 0 || echoed_count != matched_count) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

/* udp_echo_checker.sv */
/*
 * UDP echo checker
 * Models the echo responder at the receive handshakes and compares every
 * transmit transfer and the LED byte against the model's queues
 */
module udp_echo_checker (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              rx_hdr_valid,
    input  logic                              rx_hdr_ready,
    input  logic [udp_echo_pkg::IP_W-1:0]     rx_ip_source_ip,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_source_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_dest_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_length,
    input  logic [udp_echo_pkg::DATA_W-1:0]   rx_payload_tdata,
    input  logic [udp_echo_pkg::KEEP_W-1:0]   rx_payload_tkeep,
    input  logic                              rx_payload_tvalid,
    input  logic                              rx_payload_tready,
    input  logic                              rx_payload_tlast,
    input  logic                              rx_payload_tuser,

    input  logic                              tx_hdr_valid,
    input  logic                              tx_hdr_ready,
    input  logic [udp_echo_pkg::IP_W-1:0]     tx_ip_dest_ip,
    input  logic [udp_echo_pkg::PORT_W-1:0]   tx_source_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   tx_dest_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   tx_length,
    input  logic [udp_echo_pkg::DATA_W-1:0]   tx_payload_tdata,
    input  logic [udp_echo_pkg::KEEP_W-1:0]   tx_payload_tkeep,
    input  logic                              tx_payload_tvalid,
    input  logic                              tx_payload_tready,
    input  logic                              tx_payload_tlast,
    input  logic                              tx_payload_tuser,
    input  logic [7:0]                        led,

    output int                                error_count,
    output int                                pending,
    output int                                matched_count,
    output int                                echoed_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import udp_echo_pkg::*;

    // Expected reply headers, already swapped
    logic [IP_W-1:0]   exp_ip [$];
    logic [PORT_W-1:0] exp_sport [$];
    logic [PORT_W-1:0] exp_dport [$];
    logic [PORT_W-1:0] exp_len [$];

    // Expected payload words and LED bytes
    logic [DATA_W-1:0] exp_data [$];
    logic [KEEP_W-1:0] exp_keep [$];
    logic              exp_last [$];
    logic              exp_user [$];
    logic [7:0]        exp_led [$];

    logic       in_match;
    logic       in_first;
    logic       out_in_frame;
    logic       out_first;
    logic       led_due;
    logic [7:0] led_exp;
    logic       reset_check;

    initial begin
        error_count   = 0;
        pending       = 0;
        matched_count = 0;
        echoed_count  = 0;
    end

    function automatic void compare_field(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            error_count++;
        end
    endfunction

    function automatic void report_problem(string what);
        $display("%s at %0t", what, $time);
        error_count++;
    endfunction

    // Reference model at the receive handshakes
    function automatic void model_input();
        if (rx_hdr_valid && rx_hdr_ready) begin
            in_match = (rx_dest_port == ECHO_PORT);
            in_first = 1'b1;
            if (in_match) begin
                exp_ip.push_back(rx_ip_source_ip);
                exp_sport.push_back(rx_dest_port);
                exp_dport.push_back(rx_source_port);
                exp_len.push_back(rx_length);
                matched_count++;
            end
        end
        if (rx_payload_tvalid && rx_payload_tready) begin
            if (in_match) begin
                exp_data.push_back(rx_payload_tdata);
                exp_keep.push_back(rx_payload_tkeep);
                exp_last.push_back(rx_payload_tlast);
                exp_user.push_back(rx_payload_tuser);
                if (in_first) begin
                    exp_led.push_back(rx_payload_tdata[7:0]);
                end
            end
            in_first = rx_payload_tlast;
        end
    endfunction

    function automatic void check_tx_header();
        if (out_in_frame) begin
            report_problem("tx header sent before the previous reply payload ended");
        end
        if (exp_ip.size() == 0) begin
            report_problem("tx header sent with no matching frame received");
        end else begin
            compare_field("tx_ip_dest_ip", 64'(tx_ip_dest_ip), 64'(exp_ip.pop_front()));
            compare_field("tx_source_port", 64'(tx_source_port), 64'(exp_sport.pop_front()));
            compare_field("tx_dest_port", 64'(tx_dest_port), 64'(exp_dport.pop_front()));
            compare_field("tx_length", 64'(tx_length), 64'(exp_len.pop_front()));
        end
        out_in_frame = 1'b1;
        out_first    = 1'b1;
    endfunction

    function automatic void check_tx_payload();
        if (!out_in_frame) begin
            report_problem("tx payload word sent before its reply header");
        end
        if (exp_data.size() == 0) begin
            report_problem("tx payload word sent with no matching word received");
        end else begin
            compare_field("tx_payload_tdata", tx_payload_tdata, exp_data.pop_front());
            compare_field("tx_payload_tkeep", 64'(tx_payload_tkeep), 64'(exp_keep.pop_front()));
            compare_field("tx_payload_tlast", 64'(tx_payload_tlast), 64'(exp_last.pop_front()));
            compare_field("tx_payload_tuser", 64'(tx_payload_tuser), 64'(exp_user.pop_front()));
        end
        // LED follows the first word one cycle later
        if (out_first && exp_led.size() != 0) begin
            led_exp = exp_led.pop_front();
            led_due = 1'b1;
        end
        out_first = tx_payload_tlast;
        if (tx_payload_tlast) begin
            out_in_frame = 1'b0;
            echoed_count++;
        end
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            in_match     = 1'b0;
            in_first     = 1'b1;
            out_in_frame = 1'b0;
            out_first    = 1'b1;
            led_due      = 1'b0;
            reset_check  = 1'b1;
        end else begin
            if (reset_check) begin
                compare_field("tx_hdr_valid", 64'(tx_hdr_valid), 64'd0);
                compare_field("tx_payload_tvalid", 64'(tx_payload_tvalid), 64'd0);
                compare_field("led", 64'(led), 64'd0);
                reset_check = 1'b0;
            end
            if (led_due) begin
                compare_field("led", 64'(led), 64'(led_exp));
                led_due = 1'b0;
            end
            model_input();
            if (tx_hdr_valid && tx_hdr_ready) begin
                check_tx_header();
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                check_tx_payload();
            end
        end
        pending = exp_ip.size() + exp_data.size() + exp_led.size() + int'(led_due);
    end

endmodule

/* udp_echo_top.sv */
/*
 * UDP echo responder
 * Filter, payload FIFO and reply stage in a three-stage pipeline
 */
module udp_echo_top (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              rx_hdr_valid,
    output logic                              rx_hdr_ready,
    input  logic [udp_echo_pkg::IP_W-1:0]     rx_ip_source_ip,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_source_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_dest_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_length,

    input  logic [udp_echo_pkg::DATA_W-1:0]   rx_payload_tdata,
    input  logic [udp_echo_pkg::KEEP_W-1:0]   rx_payload_tkeep,
    input  logic                              rx_payload_tvalid,
    output logic                              rx_payload_tready,
    input  logic                              rx_payload_tlast,
    input  logic                              rx_payload_tuser,

    output logic                              tx_hdr_valid,
    input  logic                              tx_hdr_ready,
    output logic [udp_echo_pkg::IP_W-1:0]     tx_ip_dest_ip,
    output logic [udp_echo_pkg::PORT_W-1:0]   tx_source_port,
    output logic [udp_echo_pkg::PORT_W-1:0]   tx_dest_port,
    output logic [udp_echo_pkg::PORT_W-1:0]   tx_length,

    output logic [udp_echo_pkg::DATA_W-1:0]   tx_payload_tdata,
    output logic [udp_echo_pkg::KEEP_W-1:0]   tx_payload_tkeep,
    output logic                              tx_payload_tvalid,
    input  logic                              tx_payload_tready,
    output logic                              tx_payload_tlast,
    output logic                              tx_payload_tuser,

    output logic [7:0]                        led
);
    import udp_echo_pkg::*;

    // Unswapped header from filter to reply stage
    logic              fwd_hdr_valid;
    logic              fwd_hdr_ready;
    logic [IP_W-1:0]   fwd_ip_source_ip;
    logic [PORT_W-1:0] fwd_source_port;
    logic [PORT_W-1:0] fwd_dest_port;
    logic [PORT_W-1:0] fwd_length;

    // Matched payload into the FIFO
    logic [DATA_W-1:0] fifo_in_tdata;
    logic [KEEP_W-1:0] fifo_in_tkeep;
    logic              fifo_in_tvalid;
    logic              fifo_in_tready;
    logic              fifo_in_tlast;
    logic              fifo_in_tuser;

    // Buffered payload out to the reply stage
    logic [DATA_W-1:0] fifo_out_tdata;
    logic [KEEP_W-1:0] fifo_out_tkeep;
    logic              fifo_out_tvalid;
    logic              fifo_out_tready;
    logic              fifo_out_tlast;
    logic              fifo_out_tuser;

    udp_port_filter u_filter (.*);

    udp_payload_fifo u_fifo (.*);

    udp_reply_tx u_reply (.*);

endmodule

/* udp_reply_tx.sv */
/*
 * UDP reply stage
 * Holds one swapped reply header, sends it ahead of its payload and
 * shows the first payload byte of each echoed frame on the LEDs
 */
module udp_reply_tx (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              fwd_hdr_valid,
    output logic                              fwd_hdr_ready,
    input  logic [udp_echo_pkg::IP_W-1:0]     fwd_ip_source_ip,
    input  logic [udp_echo_pkg::PORT_W-1:0]   fwd_source_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   fwd_dest_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   fwd_length,

    input  logic [udp_echo_pkg::DATA_W-1:0]   fifo_out_tdata,
    input  logic [udp_echo_pkg::KEEP_W-1:0]   fifo_out_tkeep,
    input  logic                              fifo_out_tvalid,
    output logic                              fifo_out_tready,
    input  logic                              fifo_out_tlast,
    input  logic                              fifo_out_tuser,

    output logic                              tx_hdr_valid,
    input  logic                              tx_hdr_ready,
    output logic [udp_echo_pkg::IP_W-1:0]     tx_ip_dest_ip,
    output logic [udp_echo_pkg::PORT_W-1:0]   tx_source_port,
    output logic [udp_echo_pkg::PORT_W-1:0]   tx_dest_port,
    output logic [udp_echo_pkg::PORT_W-1:0]   tx_length,

    output logic [udp_echo_pkg::DATA_W-1:0]   tx_payload_tdata,
    output logic [udp_echo_pkg::KEEP_W-1:0]   tx_payload_tkeep,
    output logic                              tx_payload_tvalid,
    input  logic                              tx_payload_tready,
    output logic                              tx_payload_tlast,
    output logic                              tx_payload_tuser,

    output logic [7:0]                        led
);
    import udp_echo_pkg::*;

    tx_state_t         state;
    logic              slot_valid;
    logic [IP_W-1:0]   slot_dest_ip;
    logic [PORT_W-1:0] slot_src_port;
    logic [PORT_W-1:0] slot_dst_port;
    logic [PORT_W-1:0] slot_length;
    logic              first_beat;
    logic              fwd_xfer;
    logic              hdr_xfer;
    logic              pay_xfer;

    assign fwd_hdr_ready = !slot_valid;
    assign fwd_xfer      = fwd_hdr_valid && fwd_hdr_ready;

    // Header goes out only between frames
    assign tx_hdr_valid   = slot_valid && (state == TX_HDR);
    assign tx_ip_dest_ip  = slot_dest_ip;
    assign tx_source_port = slot_src_port;
    assign tx_dest_port   = slot_dst_port;
    assign tx_length      = slot_length;
    assign hdr_xfer       = tx_hdr_valid && tx_hdr_ready;

    assign tx_payload_tdata  = fifo_out_tdata;
    assign tx_payload_tkeep  = fifo_out_tkeep;
    assign tx_payload_tlast  = fifo_out_tlast;
    assign tx_payload_tuser  = fifo_out_tuser;
    assign tx_payload_tvalid = fifo_out_tvalid && (state == TX_PAYLOAD);
    assign fifo_out_tready   = tx_payload_tready && (state == TX_PAYLOAD);
    assign pay_xfer          = tx_payload_tvalid && tx_payload_tready;

    // Reply addressing, back to the sender with the ports swapped
    always_ff @(posedge clk) begin
        if (fwd_xfer) begin
            slot_dest_ip  <= fwd_ip_source_ip;
            slot_src_port <= fwd_dest_port;
            slot_dst_port <= fwd_source_port;
            slot_length   <= fwd_length;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
            state      <= TX_HDR;
        end else begin
            // Never both in one cycle, ready is low while the slot is full
            if (fwd_xfer) begin
                slot_valid <= 1'b1;
            end else if (hdr_xfer) begin
                slot_valid <= 1'b0;
            end
            case (state)
                TX_HDR: begin
                    if (hdr_xfer) begin
                        state <= TX_PAYLOAD;
                    end
                end
                TX_PAYLOAD: begin
                    if (pay_xfer && tx_payload_tlast) begin
                        state <= TX_HDR;
                    end
                end
                default: begin
                    state <= TX_HDR;
                end
            endcase
        end
    end

    // Next beat after a last beat starts a new frame
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= 8'h00;
        end else if (pay_xfer) begin
            first_beat <= tx_payload_tlast;
            if (first_beat) begin
                led <= tx_payload_tdata[7:0];
            end
        end
    end

    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=>
            tx_hdr_valid && $stable(tx_ip_dest_ip) && $stable(tx_source_port)
            && $stable(tx_dest_port) && $stable(tx_length)
    ) else $error("tx header changed while stalled");

endmodule

/* udp_payload_fifo.sv */
/*
 * Payload FIFO
 * Synchronous FIFO for matched payload words with keep, last and user
 */
module udp_payload_fifo (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [udp_echo_pkg::DATA_W-1:0]   fifo_in_tdata,
    input  logic [udp_echo_pkg::KEEP_W-1:0]   fifo_in_tkeep,
    input  logic                              fifo_in_tvalid,
    output logic                              fifo_in_tready,
    input  logic                              fifo_in_tlast,
    input  logic                              fifo_in_tuser,

    output logic [udp_echo_pkg::DATA_W-1:0]   fifo_out_tdata,
    output logic [udp_echo_pkg::KEEP_W-1:0]   fifo_out_tkeep,
    output logic                              fifo_out_tvalid,
    input  logic                              fifo_out_tready,
    output logic                              fifo_out_tlast,
    output logic                              fifo_out_tuser
);
    import udp_echo_pkg::*;

    logic [DATA_W-1:0] mem_data [FIFO_DEPTH];
    logic [KEEP_W-1:0] mem_keep [FIFO_DEPTH];
    logic              mem_last [FIFO_DEPTH];
    logic              mem_user [FIFO_DEPTH];

    // Pointers carry one wrap bit above the address
    logic [FIFO_AW:0]  wr_ptr;
    logic [FIFO_AW:0]  rd_ptr;
    logic [FIFO_AW:0]  level;
    logic              full;
    logic              empty;
    logic              wr_en;
    logic              rd_en;

    assign level = wr_ptr - rd_ptr;
    // Level tops out at FIFO_DEPTH, which is the only value with the top bit set
    assign full  = level[FIFO_AW];
    assign empty = (wr_ptr == rd_ptr);

    assign fifo_in_tready  = !full;
    assign fifo_out_tvalid = !empty;
    assign wr_en           = fifo_in_tvalid && fifo_in_tready;
    assign rd_en           = fifo_out_tvalid && fifo_out_tready;

    // Head word read straight from storage
    assign fifo_out_tdata = mem_data[rd_ptr[FIFO_AW-1:0]];
    assign fifo_out_tkeep = mem_keep[rd_ptr[FIFO_AW-1:0]];
    assign fifo_out_tlast = mem_last[rd_ptr[FIFO_AW-1:0]];
    assign fifo_out_tuser = mem_user[rd_ptr[FIFO_AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[FIFO_AW-1:0]] <= fifo_in_tdata;
            mem_keep[wr_ptr[FIFO_AW-1:0]] <= fifo_in_tkeep;
            mem_last[wr_ptr[FIFO_AW-1:0]] <= fifo_in_tlast;
            mem_user[wr_ptr[FIFO_AW-1:0]] <= fifo_in_tuser;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy never passes the depth, so no write lands on a full FIFO
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        level <= (FIFO_AW + 1)'(FIFO_DEPTH)
    ) else $error("payload FIFO overflow, level %0d", level);

endmodule

/* udp_port_filter.sv */
/*
 * UDP port filter
 * Accepts received frames whose destination port is the echo port and
 * forwards their header and payload; other frames are drained and dropped
 */
module udp_port_filter (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              rx_hdr_valid,
    output logic                              rx_hdr_ready,
    input  logic [udp_echo_pkg::IP_W-1:0]     rx_ip_source_ip,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_source_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_dest_port,
    input  logic [udp_echo_pkg::PORT_W-1:0]   rx_length,

    input  logic [udp_echo_pkg::DATA_W-1:0]   rx_payload_tdata,
    input  logic [udp_echo_pkg::KEEP_W-1:0]   rx_payload_tkeep,
    input  logic                              rx_payload_tvalid,
    output logic                              rx_payload_tready,
    input  logic                              rx_payload_tlast,
    input  logic                              rx_payload_tuser,

    output logic                              fwd_hdr_valid,
    input  logic                              fwd_hdr_ready,
    output logic [udp_echo_pkg::IP_W-1:0]     fwd_ip_source_ip,
    output logic [udp_echo_pkg::PORT_W-1:0]   fwd_source_port,
    output logic [udp_echo_pkg::PORT_W-1:0]   fwd_dest_port,
    output logic [udp_echo_pkg::PORT_W-1:0]   fwd_length,

    output logic [udp_echo_pkg::DATA_W-1:0]   fifo_in_tdata,
    output logic [udp_echo_pkg::KEEP_W-1:0]   fifo_in_tkeep,
    output logic                              fifo_in_tvalid,
    input  logic                              fifo_in_tready,
    output logic                              fifo_in_tlast,
    output logic                              fifo_in_tuser
);
    import udp_echo_pkg::*;

    filt_state_t state;
    logic        port_match;
    logic        hdr_xfer;
    logic        pay_xfer;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // A matching header waits for the reply stage, others go at once
    assign rx_hdr_ready  = (state == FILT_IDLE) && (fwd_hdr_ready || !port_match);
    assign fwd_hdr_valid = (state == FILT_IDLE) && rx_hdr_valid && port_match;
    assign hdr_xfer      = rx_hdr_valid && rx_hdr_ready;

    assign fwd_ip_source_ip = rx_ip_source_ip;
    assign fwd_source_port  = rx_source_port;
    assign fwd_dest_port    = rx_dest_port;
    assign fwd_length       = rx_length;

    // Payload steering follows the verdict on the frame's header
    assign fifo_in_tdata     = rx_payload_tdata;
    assign fifo_in_tkeep     = rx_payload_tkeep;
    assign fifo_in_tlast     = rx_payload_tlast;
    assign fifo_in_tuser     = rx_payload_tuser;
    assign fifo_in_tvalid    = rx_payload_tvalid && (state == FILT_PASS);
    assign rx_payload_tready = ((state == FILT_PASS) && fifo_in_tready) || (state == FILT_DROP);
    assign pay_xfer          = rx_payload_tvalid && rx_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILT_IDLE;
        end else begin
            case (state)
                FILT_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? FILT_PASS : FILT_DROP;
                    end
                end
                FILT_PASS, FILT_DROP: begin
                    if (pay_xfer && rx_payload_tlast) begin
                        state <= FILT_IDLE;
                    end
                end
                default: begin
                    state <= FILT_IDLE;
                end
            endcase
        end
    end

    // Payload only moves once its header has been judged
    a_no_payload_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state == FILT_IDLE) |-> !pay_xfer
    ) else $error("payload transfer while filter idle");

endmodule

/* udp_echo_pkg.sv */
/*
 * UDP echo responder shared definitions
 * Stream widths, the echoed port, payload FIFO sizing and FSM encodings
 */
package udp_echo_pkg;

    // Payload stream
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // Header fields
    localparam int IP_W   = 32;
    localparam int PORT_W = 16;

    // Frames sent to this port are echoed back
    localparam logic [PORT_W-1:0] ECHO_PORT = 16'd1234;

    // Payload FIFO
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;

    // Input filter FSM
    typedef enum logic [1:0] {
        FILT_IDLE,
        FILT_PASS,
        FILT_DROP
    } filt_state_t;

    // Reply FSM, header first and then its payload
    typedef enum logic {
        TX_HDR,
        TX_PAYLOAD
    } tx_state_t;

endpackage
